/* Makefile */
# Verilator build and run of the convolution engine testbench.

SIM = obj_dir/cnn_acc_sim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module cnn_acc_tb -Mdir obj_dir -o cnn_acc_sim

run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
+incdir+include
hw/cnn_pkg.sv
hw/cnn_flow_if.sv
hw/cnn_input_stage.sv
hw/cnn_kernel.sv
hw/cnn_acc_ci.sv
hw/cnn_output_stage.sv
hw/cnn_acc_top.sv
verification/cnn_clk_gen.sv
verification/cnn_acc_asserts.sv
verification/cnn_acc_tb.sv

/* hw/cnn_acc_ci.sv */
`timescale 1ns/100ps
`include "cnn_consts.svh"

module cnn_acc_ci (
    input  logic            clk,
    input  logic            reset_n,
    cnn_flow_if.pe          flow,
    output logic            o_res_valid,
    output cnn_pkg::ciacc_t o_res_acc
);
    import cnn_pkg::*;

    localparam int KW_BW = `CNN_KX * `CNN_KY * `CNN_W_BW;  // one channel's weights.

    kacc_t              k_acc [`CNN_CI];
    logic [`CNN_CI-1:0] k_valid;
    ciacc_t             ci_sum;
    ciacc_t             r_res_acc;
    logic               r_res_valid;

    //////////////////////////////
    // one kernel per channel
    //////////////////////////////

    // same window everywhere, only the weight slice differs.
    for (genvar c = 0; c < `CNN_CI; c++) begin : g_ch
        cnn_kernel #(
            .KX     (`CNN_KX),
            .KY     (`CNN_KY),
            .PIX_BW (`CNN_PIX_BW),
            .W_BW   (`CNN_W_BW),
            .AK_BW  (`CNN_AK_BW)
        ) u_kernel (
            .clk             (clk),
            .reset_n         (reset_n),
            .i_in_valid      (flow.issue_valid),
            .i_in_fmap       (flow.issue_window),
            .i_cnn_weight    (flow.issue_weights[c*KW_BW +: KW_BW]),
            .o_ot_valid      (k_valid[c]),
            .o_ot_kernel_acc (k_acc[c])
        );
    end

    always_comb begin
        ci_sum = '0;
        for (int c = 0; c < `CNN_CI; c++) begin
            ci_sum = ci_sum + k_acc[c];  // signed, extends to ACI_BW.
        end
    end

    always_ff @(posedge clk) begin
        if (&k_valid) begin
            r_res_acc <= ci_sum;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_res_valid <= 1'b0;
        end else begin
            r_res_valid <= &k_valid;  // matches the result register.
        end
    end

    assign o_res_valid = r_res_valid;
    assign o_res_acc   = r_res_acc;

endmodule

/* hw/cnn_acc_top.sv */
`timescale 1ns/100ps

module cnn_acc_top (
    input  logic              clk,
    input  logic              reset_n,
    // upstream.
    input  logic              i_in_valid,
    input  cnn_pkg::window_t  i_window,
    input  cnn_pkg::weights_t i_weights,
    output logic              o_in_credit,
    // downstream.
    output logic              o_out_valid,
    output cnn_pkg::ciacc_t   o_out_data,
    input  logic              i_out_credit
);

    cnn_pkg::ciacc_t res_acc;
    logic            res_valid;

    cnn_flow_if flow ();

    cnn_input_stage u_input_stage (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (i_in_valid),
        .i_window    (i_window),
        .i_weights   (i_weights),
        .o_in_credit (o_in_credit),
        .flow        (flow.src)
    );

    cnn_acc_ci u_acc_ci (
        .clk         (clk),
        .reset_n     (reset_n),
        .flow        (flow.pe),
        .o_res_valid (res_valid),
        .o_res_acc   (res_acc)
    );

    cnn_output_stage u_output_stage (
        .clk          (clk),
        .reset_n      (reset_n),
        .flow         (flow.sink),
        .i_res_valid  (res_valid),
        .i_res_acc    (res_acc),
        .i_out_credit (i_out_credit),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data)
    );

endmodule

/* hw/cnn_flow_if.sv */
`timescale 1ns/100ps

interface cnn_flow_if;
    import cnn_pkg::*;

    logic     issue_valid;    // one item leaves the input buffer.
    window_t  issue_window;
    weights_t issue_weights;
    logic     room;           // an output slot is still unreserved.

    // input stage side.
    modport src (
        output issue_valid,
        output issue_window,
        output issue_weights,
        input  room
    );

    // processing part, never stalls.
    modport pe (
        input  issue_valid,
        input  issue_window,
        input  issue_weights
    );

    // output stage counts issued items against its free slots
    modport sink (
        input  issue_valid,
        output room
    );

endinterface

/* hw/cnn_input_stage.sv */
`timescale 1ns/100ps
`include "cnn_consts.svh"

module cnn_input_stage (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_in_valid,
    input  cnn_pkg::window_t  i_window,
    input  cnn_pkg::weights_t i_weights,
    output logic              o_in_credit,
    cnn_flow_if.src           flow
);
    import cnn_pkg::*;

    localparam int PTR_BW = $clog2(`CNN_IN_DEPTH);
    localparam int CNT_BW = $clog2(`CNN_IN_DEPTH + 1);

    window_t           win_mem [`CNN_IN_DEPTH];
    weights_t          wgt_mem [`CNN_IN_DEPTH];
    logic [PTR_BW-1:0] wr_ptr;
    logic [PTR_BW-1:0] rd_ptr;
    logic [CNT_BW-1:0] count;
    logic              pop;

    //////////////////////////////
    // issue and credit return
    //////////////////////////////

    assign pop                = (count != '0) && flow.room;
    assign flow.issue_valid   = pop;
    assign flow.issue_window  = win_mem[rd_ptr];  // head of buffer.
    assign flow.issue_weights = wgt_mem[rd_ptr];
    assign o_in_credit        = pop;              // freed slot goes back upstream.

    // upstream never sends without a credit, so no full check.
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            win_mem[wr_ptr] <= i_window;
            wgt_mem[wr_ptr] <= i_weights;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_in_valid) begin
                wr_ptr <= (wr_ptr == PTR_BW'(`CNN_IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BW'(`CNN_IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none or both.
            endcase
        end
    end

endmodule

/* hw/cnn_kernel.sv */
`timescale 1ns/100ps

module cnn_kernel #(
    parameter int KX     = 3,
    parameter int KY     = 3,
    parameter int PIX_BW = 8,
    parameter int W_BW   = 8,
    parameter int AK_BW  = 21
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         i_in_valid,
    input  logic [KX*KY*PIX_BW-1:0]      i_in_fmap,
    input  logic signed [KX*KY*W_BW-1:0] i_cnn_weight,
    output logic                         o_ot_valid,
    output logic signed [AK_BW-1:0]      o_ot_kernel_acc
);

    localparam int TAPS = KX * KY;
    localparam int M_BW = PIX_BW + 1 + W_BW;  // pixel gets a zero sign bit.

    logic signed [M_BW-1:0]  r_mul [TAPS];
    logic signed [AK_BW-1:0] sum;
    logic signed [AK_BW-1:0] r_acc;
    logic                    r_mul_valid;
    logic                    r_acc_valid;

    //////////////////////////////
    // stage 1, products
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int k = 0; k < TAPS; k++) begin
            r_mul[k] <= $signed({1'b0, i_in_fmap[k*PIX_BW +: PIX_BW]})
                      * $signed(i_cnn_weight[k*W_BW +: W_BW]);
        end
    end

    //////////////////////////////
    // stage 2, adder tree
    //////////////////////////////

    // all taps summed in one combinational stage.
    always_comb begin
        sum = '0;
        for (int k = 0; k < TAPS; k++) begin
            sum = sum + r_mul[k];  // sign extended to AK_BW.
        end
    end

    always_ff @(posedge clk) begin
        r_acc <= sum;
    end

    // valid travels alongside the data.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_mul_valid <= 1'b0;
            r_acc_valid <= 1'b0;
        end else begin
            r_mul_valid <= i_in_valid;
            r_acc_valid <= r_mul_valid;
        end
    end

    assign o_ot_valid      = r_acc_valid;
    assign o_ot_kernel_acc = r_acc;

endmodule

/* hw/cnn_output_stage.sv */
`timescale 1ns/100ps
`include "cnn_consts.svh"

module cnn_output_stage (
    input  logic            clk,
    input  logic            reset_n,
    cnn_flow_if.sink        flow,
    input  logic            i_res_valid,
    input  cnn_pkg::ciacc_t i_res_acc,
    input  logic            i_out_credit,
    output logic            o_out_valid,
    output cnn_pkg::ciacc_t o_out_data
);
    import cnn_pkg::*;

    localparam int PTR_BW = $clog2(`CNN_OUT_DEPTH);
    localparam int CNT_BW = $clog2(`CNN_OUT_DEPTH + 1);

    ciacc_t              out_mem [`CNN_OUT_DEPTH];
    ciacc_t              relu;
    logic [PTR_BW-1:0]   wr_ptr;
    logic [PTR_BW-1:0]   rd_ptr;
    logic [CNT_BW-1:0]   count;
    logic [CNT_BW-1:0]   in_flight;   // issued, not yet written.
    logic [CNT_BW:0]     reserved;
    logic [`CNN_CRD_BW-1:0] crd_cnt;
    logic                send;

    assign relu = i_res_acc[`CNN_ACI_BW-1] ? '0 : i_res_acc;  // clip at zero.

    //////////////////////////////
    // slot reservation
    //////////////////////////////

    // buffered plus in-flight items must stay within the depth
    assign reserved  = {1'b0, count} + {1'b0, in_flight};
    assign flow.room = reserved < (CNT_BW+1)'(`CNN_OUT_DEPTH);

    //////////////////////////////
    // buffer and credit gate
    //////////////////////////////

    assign send        = (count != '0) && (crd_cnt != '0);
    assign o_out_valid = send;
    assign o_out_data  = out_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_res_valid) begin
            out_mem[wr_ptr] <= relu;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_flight <= '0;
            crd_cnt   <= '0;
        end else begin
            if (i_res_valid) begin
                wr_ptr <= (wr_ptr == PTR_BW'(`CNN_OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_BW'(`CNN_OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_res_valid, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({flow.issue_valid, i_res_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
            case ({i_out_credit, send})
                2'b10:   crd_cnt <= crd_cnt + 1'b1;  // grant.
                2'b01:   crd_cnt <= crd_cnt - 1'b1;  // spent.
                default: crd_cnt <= crd_cnt;
            endcase
        end
    end

endmodule

/* hw/cnn_pkg.sv */
`include "cnn_consts.svh"

package cnn_pkg;

    //////////////////////////////
    // payload vectors
    //////////////////////////////

    // one flattened window, tap k at bits k*PIX_BW.
    typedef logic [`CNN_KX*`CNN_KY*`CNN_PIX_BW-1:0] window_t;

    // all channel kernels, channel c tap k at slot c*9+k.
    typedef logic [`CNN_CI*`CNN_KX*`CNN_KY*`CNN_W_BW-1:0] weights_t;

    //////////////////////////////
    // accumulators
    //////////////////////////////

    typedef logic signed [`CNN_AK_BW-1:0] kacc_t;    // one channel.
    typedef logic signed [`CNN_ACI_BW-1:0] ciacc_t;  // all channels, also output.

endpackage

/* include/cnn_consts.svh */
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// window geometry.
`define CNN_KX        3
`define CNN_KY        3
`define CNN_CI        2

// data widths.
`define CNN_PIX_BW    8   // unsigned pixel.
`define CNN_W_BW      8   // signed weight.
`define CNN_AK_BW     21  // one channel sum.
`define CNN_ACI_BW    22  // sum over all channels.

// buffer depths.
`define CNN_IN_DEPTH  4   // also the upstream starting credit.
`define CNN_OUT_DEPTH 8

// downstream credit counter width.
`define CNN_CRD_BW    8

`endif

/* verification/cnn_acc_asserts.sv */
`timescale 1ns/100ps
`include "cnn_consts.svh"

module cnn_acc_asserts (
    input logic clk,
    input logic reset_n,
    input logic i_in_valid,
    input logic o_in_credit,
    input logic o_out_valid,
    input logic i_out_credit
);

    logic [7:0] up_cnt;  // credits held upstream.
    logic [7:0] dn_cnt;  // granted, not yet spent.

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            up_cnt <= 8'(`CNN_IN_DEPTH);
            dn_cnt <= '0;
        end else begin
            up_cnt <= up_cnt + 8'(o_in_credit) - 8'(i_in_valid);
            dn_cnt <= dn_cnt + 8'(i_out_credit) - 8'(o_out_valid);
        end
    end

    //////////////////////////////
    // port rules
    //////////////////////////////

    a_out_credit: assert property (@(posedge clk) disable iff (!reset_n)
        o_out_valid |-> (dn_cnt != '0))
        else $error("o_out_valid high with no downstream credit held");

    // a credit returned in the same cycle may be used at once.
    a_in_credit: assert property (@(posedge clk) disable iff (!reset_n)
        i_in_valid |-> ((up_cnt != '0) || o_in_credit))
        else $error("i_in_valid high with no upstream credit held");

    a_reset_low: assert property (@(posedge clk)
        !reset_n |-> (!o_out_valid && !o_in_credit))
        else $error("outputs active during reset");

endmodule

/* verification/cnn_acc_tb.sv */
`timescale 1ns/100ps
`include "cnn_consts.svh"

module cnn_acc_tb;
    import cnn_pkg::*;

    localparam int TAPS = `CNN_KX * `CNN_KY;

    logic     clk;
    logic     reset_n;
    logic     i_in_valid;
    window_t  i_window;
    weights_t i_weights;
    logic     o_in_credit;
    logic     o_out_valid;
    ciacc_t   o_out_data;
    logic     i_out_credit;

    integer   seed = 92;
    int       errors;
    int       up_credits;  // upstream credits held.
    int       dn_held;     // downstream credits not yet spent.
    int       pulses;      // o_in_credit pulses seen.
    int       results;
    ciacc_t   exp_q [$];   // expected results in send order.

    cnn_clk_gen u_clk_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    cnn_acc_top uut (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .i_window     (i_window),
        .i_weights    (i_weights),
        .o_in_credit  (o_in_credit),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data),
        .i_out_credit (i_out_credit)
    );

    bind cnn_acc_top cnn_acc_asserts u_asserts (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .o_in_credit  (o_in_credit),
        .o_out_valid  (o_out_valid),
        .i_out_credit (i_out_credit)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    // sum of pixel times signed weight over all channels, clipped at zero.
    function automatic ciacc_t expected_result(input window_t w, input weights_t wt);
        int acc;
        int pix;
        int wgt;
        acc = 0;
        for (int c = 0; c < `CNN_CI; c++) begin
            for (int k = 0; k < TAPS; k++) begin
                pix = int'(w[k*`CNN_PIX_BW +: `CNN_PIX_BW]);
                wgt = int'($signed(wt[(c*TAPS+k)*`CNN_W_BW +: `CNN_W_BW]));
                acc = acc + pix * wgt;
            end
        end
        return (acc < 0) ? '0 : ciacc_t'(acc);
    endfunction

    task automatic random_item(output window_t w, output weights_t wt);
        for (int k = 0; k < TAPS; k++) begin
            w[k*`CNN_PIX_BW +: `CNN_PIX_BW] = 8'($random(seed));
        end
        for (int j = 0; j < `CNN_CI*TAPS; j++) begin
            wt[j*`CNN_W_BW +: `CNN_W_BW] = 8'($random(seed));
        end
    endtask

    //////////////////////////////
    // cycle driver and monitor
    //////////////////////////////

    task automatic sample_outputs();
        ciacc_t want;
        if (o_in_credit) begin
            up_credits++;
            pulses++;
            if (up_credits > `CNN_IN_DEPTH) begin
                $display("ERROR t=%0t more upstream credits returned than spent", $time);
                errors++;
            end
        end
        if (o_out_valid) begin
            results++;
            if (dn_held == 0) begin
                $display("ERROR t=%0t result sent while no downstream credit was held", $time);
                errors++;
            end else begin
                dn_held--;
            end
            if (exp_q.size() == 0) begin
                $display("ERROR t=%0t result arrived with none expected", $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                if (o_out_data !== want) begin
                    $display("FAIL t=%0t o_out_data got %0d expected %0d",
                             $time, o_out_data, want);
                    errors++;
                end
            end
        end
    endtask

    // outputs are sampled mid-cycle, then the next inputs are driven.
    task automatic tick(input logic want_send, input window_t w, input weights_t wt,
                        input logic want_grant, output logic sent);
        @(negedge clk);
        sample_outputs();
        sent       = want_send && (up_credits > 0);
        i_in_valid = sent;
        i_window   = w;
        i_weights  = wt;
        if (sent) begin
            up_credits--;
            exp_q.push_back(expected_result(w, wt));
        end
        i_out_credit = want_grant && (dn_held < exp_q.size());  // never more than needed.
        if (i_out_credit) begin
            dn_held++;
        end
    endtask

    task automatic idle(input int n, input logic grant);
        logic sent;
        repeat (n) tick(1'b0, '0, '0, grant, sent);
    endtask

    task automatic send_item(input window_t w, input weights_t wt, input logic rand_grant);
        logic sent;
        int   n;
        sent = 1'b0;
        n    = 0;
        while (!sent && n < 100) begin
            tick(1'b1, w, wt, rand_grant && 1'($random(seed)), sent);
            n++;
        end
        if (!sent) begin
            $display("ERROR t=%0t timeout waiting for an upstream credit", $time);
            errors++;
        end
    endtask

    // grants credits until every sent item has come out.
    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 300) begin
            idle(1, 1'b1);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR t=%0t timeout, %0d results missing", $time, exp_q.size());
            errors++;
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic check_reset();
        int n;
        n = 0;
        while (reset_n !== 1'b1 && n < 20) begin
            @(negedge clk);
            if (o_out_valid !== 1'b0 || o_in_credit !== 1'b0) begin
                $display("ERROR t=%0t outputs not low during reset", $time);
                errors++;
            end
            n++;
        end
        if (reset_n !== 1'b1) begin
            $display("ERROR t=%0t timeout waiting for reset release", $time);
            errors++;
        end
        idle(8, 1'b0);
        if (pulses != 0 || results != 0) begin
            $display("ERROR t=%0t output activity after reset with nothing sent", $time);
            errors++;
        end
    endtask

    task automatic single_window();
        window_t  w;
        weights_t wt;
        int       p0;
        int       r0;
        for (int k = 0; k < TAPS; k++) begin
            w[k*`CNN_PIX_BW +: `CNN_PIX_BW] = 8'(k + 1);
        end
        for (int j = 0; j < `CNN_CI*TAPS; j++) begin
            wt[j*`CNN_W_BW +: `CNN_W_BW] = 8'(j + 1);
        end
        p0 = pulses;
        r0 = results;
        send_item(w, wt, 1'b0);
        idle(6, 1'b0);
        if (results != r0) begin
            $display("ERROR t=%0t result appeared before a credit was granted", $time);
            errors++;
        end
        drain();
        if (results - r0 != 1 || pulses - p0 != 1) begin
            $display("ERROR t=%0t single window gave %0d results and %0d credit pulses",
                     $time, results - r0, pulses - p0);
            errors++;
        end
    endtask

    task automatic relu_clip();
        window_t  w;
        weights_t wt;
        random_item(w, wt);
        send_item({TAPS{8'd200}}, {(`CNN_CI*TAPS){8'hfd}}, 1'b0);  // negative.
        send_item(w, {{TAPS{8'hf9}}, {TAPS{8'd7}}}, 1'b0);         // channels cancel.
        send_item('0, wt, 1'b0);                                   // zero pixels.
        drain();
    endtask

    task automatic random_stream();
        window_t  w;
        weights_t wt;
        int       p0;
        p0 = pulses;
        for (int i = 0; i < 20; i++) begin
            random_item(w, wt);
            send_item(w, wt, 1'b1);
        end
        drain();
        if (pulses - p0 != 20 || up_credits != `CNN_IN_DEPTH) begin
            $display("ERROR t=%0t random stream returned %0d credit pulses, %0d credits held",
                     $time, pulses - p0, up_credits);
            errors++;
        end
    endtask

    task automatic back_pressure();
        window_t  w;
        weights_t wt;
        logic     sent;
        int       sent_cnt;
        int       quiet;
        int       r0;
        sent_cnt = 0;
        quiet    = 0;
        r0       = results;
        while (quiet < 10 && sent_cnt < 40) begin
            random_item(w, wt);
            tick(1'b1, w, wt, 1'b0, sent);
            if (sent) begin
                sent_cnt++;
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        // both buffers full, upstream out of credits.
        if (results != r0 || up_credits != 0
                || sent_cnt != `CNN_IN_DEPTH + `CNN_OUT_DEPTH) begin
            $display("ERROR t=%0t back-pressure sent %0d items, %0d outputs, %0d credits left",
                     $time, sent_cnt, results - r0, up_credits);
            errors++;
        end
        drain();
        if (up_credits != `CNN_IN_DEPTH) begin
            $display("ERROR t=%0t upstream holds %0d credits after draining", $time, up_credits);
            errors++;
        end
    endtask

    task automatic credit_granularity();
        window_t  w;
        weights_t wt;
        int       r1;
        int       n;
        for (int i = 0; i < 4; i++) begin
            random_item(w, wt);
            send_item(w, wt, 1'b0);
        end
        idle(10, 1'b0);
        for (int i = 0; i < 4; i++) begin
            r1 = results;
            idle(1, 1'b1);  // one credit.
            n = 0;
            while (results == r1 && n < 20) begin
                idle(1, 1'b0);
                n++;
            end
            idle(5, 1'b0);
            if (results != r1 + 1) begin
                $display("ERROR t=%0t one credit gave %0d results", $time, results - r1);
                errors++;
            end
        end
    endtask

    initial begin
        i_in_valid   = 1'b0;
        i_window     = '0;
        i_weights    = '0;
        i_out_credit = 1'b0;
        errors       = 0;
        up_credits   = `CNN_IN_DEPTH;
        dn_held      = 0;
        pulses       = 0;
        results      = 0;
        check_reset();
        single_window();
        relu_clip();
        random_stream();
        back_pressure();
        credit_granularity();
        idle(5, 1'b0);
        $display("errors: %0d, results checked: %0d, input credits returned: %0d",
                 errors, results, pulses);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verification/cnn_clk_gen.sv */
`timescale 1ns/100ps

module cnn_clk_gen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    initial begin
        reset_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;  // released away from the active edge.
    end

endmodule
